/* rtl/obi_pkg.sv */
// OBI-style bus types and sizing shared by the request buffer and the data memory
`default_nettype none

package obi_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus sizing
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned MEM_WORDS  = 64;
  localparam int unsigned FIFO_DEPTH = 4;

  // Index into the word array, the low bits of the word address
  localparam int unsigned MEM_IDX_W  = $clog2(MEM_WORDS);
  // Buffer pointers wrap on their own since the depth is a power of two
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  // The fill count must also represent the full state
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Request and response
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [ADDR_W-1:0] addr;    // word address, byte offset already dropped
    logic              we;
    logic              atomic;  // set together with we for a swap
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } obi_resp_t;

endpackage

`default_nettype wire

/* rtl/lsu_pkg.sv */
// Core-side command, response and alignment checker types for the load/store path
`default_nettype none

package lsu_pkg;
  import obi_pkg::*;

  // Limit on bus transactions in flight as seen from the front end
  localparam int unsigned MAX_OUTSTANDING = 4;
  // Counter width, the count may reach MAX_OUTSTANDING itself
  localparam int unsigned OUTST_CNT_W     = $clog2(MAX_OUTSTANDING + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Commands
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    LSU_LOAD  = 2'b00,
    LSU_STORE = 2'b01,
    LSU_PLOAD = 2'b10,
    LSU_SWAP  = 2'b11
  } lsu_op_e;

  typedef struct packed {
    lsu_op_e           op;
    logic [ADDR_W-1:0] addr;   // byte address
    logic [DATA_W-1:0] wdata;
  } lsu_cmd_t;

  ////////////////////////////////////////////////////////////////////////////
  // Responses and checker state
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ALIGN_OK     = 2'b00,
    ALIGN_RE_ERR = 2'b01,
    ALIGN_WR_ERR = 2'b10
  } align_status_e;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    align_status_e     status;
  } lsu_rsp_t;

  typedef enum logic [2:0] {
    ALIGN_IDLE        = 3'd0,
    ALIGN_WR_ERR_WAIT = 3'd1,
    ALIGN_RE_ERR_WAIT = 3'd2,
    ALIGN_WR_ERR_RESP = 3'd3,
    ALIGN_RE_ERR_RESP = 3'd4
  } align_state_e;

  // The checker forwards the core request untouched, so both sides share one layout
  typedef obi_req_t core_req_t;

endpackage

`default_nettype wire

/* rtl/lsu_front.sv */
// Front end that turns commands into bus requests, tracks outstanding work and registers responses
`timescale 1ns/1ns
`default_nettype none

module lsu_front import lsu_pkg::*, obi_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             cmd_valid_i,
  input  wire lsu_cmd_t   cmd_i,
  output logic            cmd_ready_o,
  output logic            rsp_valid_o,
  output lsu_rsp_t        rsp_o,
  output logic            core_trans_valid_o,
  input  wire             core_trans_ready_i,
  output obi_req_t        core_trans_o,
  output logic            align_check_en_o,
  output logic            misaligned_o,
  input  wire             align_err_i,
  input  wire             core_resp_valid_i,
  input  wire lsu_rsp_t   core_resp_i,
  output logic            one_txn_pend_n_o
);

  core_req_t              req;
  logic                   room;
  logic                   accept;
  logic                   err_rsp;
  logic                   err_pend_q;
  logic [OUTST_CNT_W-1:0] cnt_q;
  logic [OUTST_CNT_W-1:0] cnt_n;
  logic [OUTST_CNT_W-1:0] bus_cnt;
  logic                   rsp_valid_q;
  lsu_rsp_t               rsp_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request build
  ////////////////////////////////////////////////////////////////////////////

  // Drop the byte offset, the memory only sees words
  always_comb begin
    req        = '0;
    req.addr   = {2'b00, cmd_i.addr[ADDR_W-1:2]};
    req.we     = (cmd_i.op == LSU_STORE) || (cmd_i.op == LSU_SWAP);
    req.atomic = (cmd_i.op == LSU_SWAP);
    req.wdata  = cmd_i.wdata;
  end

  assign core_trans_o     = req;
  // Only pointer loads and swaps have an alignment rule
  assign align_check_en_o = (cmd_i.op == LSU_PLOAD) || (cmd_i.op == LSU_SWAP);
  assign misaligned_o     = |cmd_i.addr[1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding count
  ////////////////////////////////////////////////////////////////////////////

  // A request the checker consumed never reaches the bus, so leave it out here
  assign bus_cnt = cnt_q - OUTST_CNT_W'(err_pend_q);
  assign room    = (bus_cnt < OUTST_CNT_W'(MAX_OUTSTANDING));

  assign core_trans_valid_o = cmd_valid_i && room;
  assign cmd_ready_o        = core_trans_ready_i && room;
  assign accept             = core_trans_valid_o && core_trans_ready_i;
  assign err_rsp            = core_resp_valid_i && (core_resp_i.status != ALIGN_OK);

  // Every accepted request counts, a consumed one included, and every response retires one
  always_comb begin
    cnt_n = cnt_q;
    if (accept && !core_resp_valid_i) begin
      cnt_n = cnt_q + 1'b1;
    end else if (!accept && core_resp_valid_i) begin
      cnt_n = cnt_q - 1'b1;
    end
  end

  // Tells the checker that only one transaction will remain next cycle
  assign one_txn_pend_n_o = (cnt_n == OUTST_CNT_W'(1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q       <= '0;
      err_pend_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      cnt_q       <= cnt_n;
      rsp_valid_q <= core_resp_valid_i;
      if (accept && align_err_i) begin
        err_pend_q <= 1'b1;
      end else if (err_rsp) begin
        err_pend_q <= 1'b0;
      end
    end
  end

  // Response register, the outside is always ready
  always_ff @(posedge clk) begin
    if (core_resp_valid_i) begin
      rsp_q <= core_resp_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

/* rtl/lsu_align_check.sv */
// Alignment checker that consumes misaligned pointer loads and swaps and answers them in order
`timescale 1ns/1ns
`default_nettype none

module lsu_align_check import lsu_pkg::*, obi_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             align_check_en_i,
  input  wire             misaligned_i,
  input  wire             core_trans_valid_i,
  output logic            core_trans_ready_o,
  input  wire obi_req_t   core_trans_i,
  output logic            core_resp_valid_o,
  output lsu_rsp_t        core_resp_o,
  output logic            bus_trans_valid_o,
  input  wire             bus_trans_ready_i,
  output obi_req_t        bus_trans_o,
  input  wire             bus_resp_valid_i,
  input  wire obi_resp_t  bus_resp_i,
  input  wire             core_one_txn_pend_n_i,
  output logic            core_align_err_o
);

  logic          align_err;
  logic          trans_we;
  logic          block_core;
  logic          block_bus;
  logic          err_accept;
  logic          err_resp_valid;
  align_status_e err_status;
  align_state_e  state_q;
  align_state_e  state_n;

  // Only checked opcodes can fail
  assign align_err        = align_check_en_i && misaligned_i;
  assign core_align_err_o = align_err;
  // A swap writes, a pointer load does not, which picks the error kind
  assign trans_we         = core_trans_i.we;

  ////////////////////////////////////////////////////////////////////////////
  // Error FSM
  ////////////////////////////////////////////////////////////////////////////

  // A failed request is taken off the core side but never sent to the bus.
  // New traffic stays blocked until all earlier responses are back, and the
  // error answer then takes the slot of the consumed request
  always_comb begin
    state_n        = state_q;
    block_core     = 1'b0;
    block_bus      = 1'b0;
    err_accept     = 1'b0;
    err_resp_valid = 1'b0;
    err_status     = ALIGN_OK;

    case (state_q)
      ALIGN_IDLE: begin
        if (align_err && core_trans_valid_i) begin
          block_bus  = 1'b1;
          err_accept = 1'b1;
          // With nothing else in flight the answer can go out next cycle
          if (trans_we) begin
            state_n = core_one_txn_pend_n_i ? ALIGN_WR_ERR_RESP : ALIGN_WR_ERR_WAIT;
          end else begin
            state_n = core_one_txn_pend_n_i ? ALIGN_RE_ERR_RESP : ALIGN_RE_ERR_WAIT;
          end
        end
      end

      ALIGN_WR_ERR_WAIT,
      ALIGN_RE_ERR_WAIT: begin
        block_core = 1'b1;
        block_bus  = 1'b1;
        // Last earlier response arrives this cycle
        if (core_one_txn_pend_n_i) begin
          state_n = (state_q == ALIGN_WR_ERR_WAIT) ? ALIGN_WR_ERR_RESP : ALIGN_RE_ERR_RESP;
        end
      end

      ALIGN_WR_ERR_RESP,
      ALIGN_RE_ERR_RESP: begin
        block_core     = 1'b1;
        block_bus      = 1'b1;
        err_resp_valid = 1'b1;
        err_status     = (state_q == ALIGN_WR_ERR_RESP) ? ALIGN_WR_ERR : ALIGN_RE_ERR;
        // The core never stalls a response, one cycle is enough
        state_n        = ALIGN_IDLE;
      end

      default: begin
        state_n = ALIGN_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGN_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request and response paths
  ////////////////////////////////////////////////////////////////////////////

  assign bus_trans_valid_o  = core_trans_valid_i && !block_bus;
  assign bus_trans_o        = core_trans_i;
  assign core_trans_ready_o = (bus_trans_ready_i && !block_core) || err_accept;

  // No bus response can coincide with the error answer, the path is drained by then
  always_comb begin
    core_resp_valid_o  = bus_resp_valid_i || err_resp_valid;
    core_resp_o.rdata  = err_resp_valid ? '0 : bus_resp_i.rdata;
    core_resp_o.status = err_status;
  end

endmodule

`default_nettype wire

/* rtl/obi_req_fifo.sv */
// Circular request buffer between the alignment checker and the data memory
`timescale 1ns/1ns
`default_nettype none

module obi_req_fifo import obi_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             push_i,
  input  wire obi_req_t   push_req_i,
  output logic            ready_o,
  input  wire             pop_i,
  output logic            valid_o,
  output obi_req_t        pop_req_o
);

  obi_req_t              mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  assign full    = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign valid_o = (count_q != '0);
  // A pop in the same cycle frees the slot a push needs when full
  assign ready_o = !full || pop_i;

  assign do_push   = push_i && ready_o;
  assign do_pop    = pop_i && valid_o;
  assign pop_req_o = mem_q[rd_ptr_q];

  // Pointers and fill count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Entry storage, visible at the output one cycle after the write
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_req_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/data_sram_slave.sv */
// Word-addressed data memory that serves loads, stores and swaps with a one-cycle response
`timescale 1ns/1ns
`default_nettype none

module data_sram_slave import obi_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             req_valid_i,
  input  wire obi_req_t   req_i,
  output logic            pop_o,
  output logic            resp_valid_o,
  output obi_resp_t       resp_o
);

  logic [DATA_W-1:0]    mem_q [MEM_WORDS];
  logic [MEM_IDX_W-1:0] idx;
  logic [DATA_W-1:0]    old_word;
  logic                 plain_store;
  logic                 resp_valid_q;
  obi_resp_t            resp_q;

  // Always ready, so a request is taken in the cycle it shows up
  assign pop_o = req_valid_i;

  // Word address wraps onto the array
  assign idx         = req_i.addr[MEM_IDX_W-1:0];
  assign old_word    = mem_q[idx];
  assign plain_store = req_i.we && !req_i.atomic;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Stores and swaps both write the new word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (req_valid_i && req_i.we) begin
      mem_q[idx] <= req_i.wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= req_valid_i;
    end
  end

  // Loads and swaps return the word as it was before this access, a store returns zero
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      resp_q.rdata <= plain_store ? '0 : old_word;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

`default_nettype wire

/* rtl/lsu_subsys_top.sv */
// Load/store subsystem top joining front end, alignment checker, request buffer and memory
`timescale 1ns/1ns
`default_nettype none

module lsu_subsys_top import lsu_pkg::*, obi_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             cmd_valid_i,
  input  wire lsu_cmd_t   cmd_i,
  output logic            cmd_ready_o,
  output logic            rsp_valid_o,
  output lsu_rsp_t        rsp_o
);

  // Front end to checker
  logic      core_trans_valid;
  logic      core_trans_ready;
  obi_req_t  core_trans;
  logic      align_check_en;
  logic      misaligned;
  logic      align_err;
  logic      one_txn_pend_n;
  logic      core_resp_valid;
  lsu_rsp_t  core_resp;

  // Checker to buffer, memory back to checker
  logic      bus_trans_valid;
  logic      bus_trans_ready;
  obi_req_t  bus_trans;
  logic      bus_resp_valid;
  obi_resp_t bus_resp;

  // Buffer to memory
  logic      fifo_valid;
  logic      fifo_pop;
  obi_req_t  fifo_req;

  lsu_front u_front (
    .clk                (clk),
    .rst_n              (rst_n),
    .cmd_valid_i        (cmd_valid_i),
    .cmd_i              (cmd_i),
    .cmd_ready_o        (cmd_ready_o),
    .rsp_valid_o        (rsp_valid_o),
    .rsp_o              (rsp_o),
    .core_trans_valid_o (core_trans_valid),
    .core_trans_ready_i (core_trans_ready),
    .core_trans_o       (core_trans),
    .align_check_en_o   (align_check_en),
    .misaligned_o       (misaligned),
    .align_err_i        (align_err),
    .core_resp_valid_i  (core_resp_valid),
    .core_resp_i        (core_resp),
    .one_txn_pend_n_o   (one_txn_pend_n)
  );

  lsu_align_check u_align_check (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .align_check_en_i      (align_check_en),
    .misaligned_i          (misaligned),
    .core_trans_valid_i    (core_trans_valid),
    .core_trans_ready_o    (core_trans_ready),
    .core_trans_i          (core_trans),
    .core_resp_valid_o     (core_resp_valid),
    .core_resp_o           (core_resp),
    .bus_trans_valid_o     (bus_trans_valid),
    .bus_trans_ready_i     (bus_trans_ready),
    .bus_trans_o           (bus_trans),
    .bus_resp_valid_i      (bus_resp_valid),
    .bus_resp_i            (bus_resp),
    .core_one_txn_pend_n_i (one_txn_pend_n),
    .core_align_err_o      (align_err)
  );

  obi_req_fifo u_req_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_i     (bus_trans_valid),
    .push_req_i (bus_trans),
    .ready_o    (bus_trans_ready),
    .pop_i      (fifo_pop),
    .valid_o    (fifo_valid),
    .pop_req_o  (fifo_req)
  );

  data_sram_slave u_sram (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (fifo_valid),
    .req_i        (fifo_req),
    .pop_o        (fifo_pop),
    .resp_valid_o (bus_resp_valid),
    .resp_o       (bus_resp)
  );

endmodule

`default_nettype wire

/* dv/lsu_subsys_tb.sv */
// Testbench for the load/store subsystem with random traffic checked against a memory model
`timescale 1ns/1ns
`default_nettype none

module lsu_subsys_tb import lsu_pkg::*, obi_pkg::*; ();

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 8;
  localparam int IDLE_TAIL      = 20;
  localparam int CYCLES_PER_CMD = 400;
  // Command counts of the six test phases
  localparam int T1_PAIRS       = 16;
  localparam int T2_SWAPS       = 8;
  localparam int T3_ROUNDS      = 8;
  localparam int T4_ROUNDS      = 8;
  localparam int T5_CMDS        = 40;
  localparam int T6_CMDS        = 300;
  localparam int TOTAL_CMDS     = 2 * T1_PAIRS + 2 * T2_SWAPS + 4 * T3_ROUNDS
                                + 2 * T4_ROUNDS + T5_CMDS + T6_CMDS;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + CYCLES_PER_CMD * TOTAL_CMDS;

  logic     clk;
  logic     rst_n;
  logic     cmd_valid;
  lsu_cmd_t cmd;
  logic     cmd_ready;
  logic     rsp_valid;
  lsu_rsp_t rsp;

  integer            seed = 32'h542a_c455;
  // Model of the data memory, indexed by word address modulo the memory size
  logic [DATA_W-1:0] model_mem [MEM_WORDS];
  // Expected responses in command order
  lsu_rsp_t          exp_q [$];

  lsu_subsys_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .cmd_ready_o (cmd_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch at %0t ns: %s got 0x%08h expected 0x%08h",
                                  $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic lsu_cmd_t make_cmd(input lsu_op_e op, input logic [31:0] addr,
                                        input logic [31:0] wdata);
    lsu_cmd_t c;
    c.op    = op;
    c.addr  = addr;
    c.wdata = wdata;
    return c;
  endfunction

  // Predicts the response of one command and applies its effect on memory
  function automatic lsu_rsp_t predict_rsp(input lsu_cmd_t c);
    lsu_rsp_t             r;
    logic [MEM_IDX_W-1:0] idx;
    logic                 misal;
    r.rdata  = '0;
    r.status = ALIGN_OK;
    // Byte offset dropped, then the word address wraps onto the array
    idx      = c.addr[MEM_IDX_W+1:2];
    misal    = (c.addr[1:0] != 2'b00);
    case (c.op)
      LSU_LOAD: begin
        r.rdata = model_mem[idx];
      end
      LSU_STORE: begin
        model_mem[idx] = c.wdata;
      end
      LSU_PLOAD: begin
        if (misal) begin
          r.status = ALIGN_RE_ERR;
        end else begin
          r.rdata = model_mem[idx];
        end
      end
      default: begin
        // A swap that fails leaves memory alone
        if (misal) begin
          r.status = ALIGN_WR_ERR;
        end else begin
          r.rdata        = model_mem[idx];
          model_mem[idx] = c.wdata;
        end
      end
    endcase
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Driver and monitor
  ////////////////////////////////////////////////////////////////////////////

  // Holds the command until the DUT takes it and leaves valid high afterwards
  task automatic send_cmd(input lsu_cmd_t c);
    bit taken;
    taken = 1'b0;
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd       = c;
    while (!taken) begin
      // Ready has settled well before the next rising edge
      #(CLK_PERIOD / 4);
      if (cmd_ready) begin
        taken = 1'b1;
        exp_q.push_back(predict_rsp(c));
      end else begin
        @(negedge clk);
      end
    end
  endtask

  task automatic drain_path();
    @(negedge clk);
    cmd_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic check_response();
    lsu_rsp_t exp;
    if (exp_q.size() == 0) begin
      stop_with_failure("a response arrived with no command outstanding");
    end
    exp = exp_q.pop_front();
    check_equal("rsp_o.status", 32'(rsp.status), 32'(exp.status));
    check_equal("rsp_o.rdata", rsp.rdata, exp.rdata);
  endtask

  // Responses are registered, so the falling edge sees them stable
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && rsp_valid) begin
        check_response();
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_failure("watchdog expired before all commands completed");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test phases
  ////////////////////////////////////////////////////////////////////////////

  task automatic store_then_load();
    logic [31:0] addrs [T1_PAIRS];
    logic [31:0] r;
    for (int i = 0; i < T1_PAIRS; i++) begin
      r        = rand_word();
      addrs[i] = {r[31:2], 2'b00};
      send_cmd(make_cmd(LSU_STORE, addrs[i], rand_word()));
    end
    for (int i = 0; i < T1_PAIRS; i++) begin
      send_cmd(make_cmd(LSU_LOAD, addrs[i], 32'd0));
    end
  endtask

  // Each swap returns the old word and the load behind it sees the new one
  task automatic swap_and_reload();
    logic [31:0] r;
    logic [31:0] addr;
    for (int i = 0; i < T2_SWAPS; i++) begin
      r    = rand_word();
      addr = {26'd0, r[5:2], 2'b00};
      send_cmd(make_cmd(LSU_SWAP, addr, rand_word()));
      send_cmd(make_cmd(LSU_LOAD, addr, 32'd0));
    end
  endtask

  task automatic misaligned_checked_ops();
    logic [31:0] r;
    logic [31:0] base;
    logic [1:0]  off;
    for (int i = 0; i < T3_ROUNDS; i++) begin
      r    = rand_word();
      base = {r[31:2], 2'b00};
      off  = 2'(1 + (r % 3));
      send_cmd(make_cmd(LSU_STORE, base, rand_word()));
      send_cmd(make_cmd(LSU_PLOAD, base | 32'(off), 32'd0));
      send_cmd(make_cmd(LSU_SWAP, base | 32'(off), rand_word()));
      // The aligned pointer load shows the stored word survived
      send_cmd(make_cmd(LSU_PLOAD, base, 32'd0));
    end
  endtask

  task automatic misaligned_plain_ops();
    logic [31:0] r;
    logic [31:0] base;
    for (int i = 0; i < T4_ROUNDS; i++) begin
      r    = rand_word();
      base = {r[31:2], 2'b00};
      send_cmd(make_cmd(LSU_STORE, base | 32'(r[1:0]), rand_word()));
      send_cmd(make_cmd(LSU_LOAD, base | 32'(2'(r[3:2] | 2'b01)), 32'd0));
    end
  endtask

  // Errors land between good commands on a handful of words
  task automatic errors_between_traffic();
    logic [31:0] r;
    logic [31:0] addr;
    for (int i = 0; i < T5_CMDS; i++) begin
      r    = rand_word();
      addr = {27'd0, r[4:2], 2'b00};
      case (i % 4)
        0: send_cmd(make_cmd(LSU_PLOAD, addr | 32'(2'(1 + (r % 3))), 32'd0));
        1: send_cmd(make_cmd(LSU_STORE, addr, rand_word()));
        2: send_cmd(make_cmd(LSU_SWAP, addr | 32'(2'(1 + (r % 3))), rand_word()));
        default: send_cmd(make_cmd(lsu_op_e'(r[6:5]), addr | 32'(r[1:0]), rand_word()));
      endcase
    end
  endtask

  task automatic random_burst();
    logic [31:0] r;
    lsu_cmd_t    c;
    for (int i = 0; i < T6_CMDS; i++) begin
      r = rand_word();
      c = make_cmd(lsu_op_e'(r[1:0]), rand_word(), rand_word());
      // Keep most accesses aligned so the bus side stays busy
      if (r[4:2] != 3'd0) begin
        c.addr[1:0] = 2'b00;
      end
      send_cmd(c);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    check_equal("rsp_valid_o", 32'(rsp_valid), 32'd0);

    store_then_load();
    drain_path();
    swap_and_reload();
    drain_path();
    misaligned_checked_ops();
    drain_path();
    misaligned_plain_ops();
    drain_path();
    errors_between_traffic();
    drain_path();
    random_burst();
    drain_path();

    // Quiet tail so a stray response would still be caught
    repeat (IDLE_TAIL) @(negedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
rtl/obi_pkg.sv
rtl/lsu_pkg.sv
rtl/lsu_front.sv
rtl/lsu_align_check.sv
rtl/obi_req_fifo.sv
rtl/data_sram_slave.sv
rtl/lsu_subsys_top.sv
dv/lsu_subsys_tb.sv

/* Makefile */
# Verilator flow for the load/store subsystem testbench

VERILATOR ?= verilator
TOP       ?= lsu_subsys_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# The run log decides the result, the simulator exit code is not used
sim: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
